/* logic/reservation_station.sv */
module reservation_station (
    input  logic            clk,
    input  logic            reset,

    // Dispatch from rename
    input  logic            disp_valid,
    input  rs_pkg::t_robid  disp_robid,
    input  rs_pkg::t_preg   disp_pdst,
    input  rs_pkg::t_opcode disp_opcode,
    input  rs_pkg::t_imm    disp_imm,
    input  rs_pkg::t_preg   disp_psrc1,
    input  logic            disp_psrc1_pend,
    input  rs_pkg::t_preg   disp_psrc2,
    input  logic            disp_psrc2_pend,
    output logic            disp_ready,

    // Register file write ports
    input  logic            iprf_wr_en   [rs_pkg::IPRF_NUM_WRITES-1:0],
    input  rs_pkg::t_preg   iprf_wr_preg [rs_pkg::IPRF_NUM_WRITES-1:0],

    input  logic            nuke,

    // Issue to execution
    output logic            iss_valid,
    output rs_pkg::t_robid  iss_robid,
    output rs_pkg::t_preg   iss_pdst,
    output rs_pkg::t_opcode iss_opcode,
    output rs_pkg::t_imm    iss_imm,
    output rs_pkg::t_preg   iss_psrc1,
    output rs_pkg::t_preg   iss_psrc2
);

    import rs_pkg::*;

    t_rs_mask entry_valid;
    t_rs_mask alloc;
    t_rs_mask req;
    t_rs_mask grant;

    t_robid  e_robid  [RS_NUM_ENTRIES-1:0];
    t_preg   e_pdst   [RS_NUM_ENTRIES-1:0];
    t_opcode e_opcode [RS_NUM_ENTRIES-1:0];
    t_imm    e_imm    [RS_NUM_ENTRIES-1:0];
    t_preg   e_psrc1  [RS_NUM_ENTRIES-1:0];
    t_preg   e_psrc2  [RS_NUM_ENTRIES-1:0];

    rs_alloc_select i_rs_alloc_select (
        .entry_valid (entry_valid),
        .disp_valid  (disp_valid),
        .nuke        (nuke),
        .alloc       (alloc),
        .disp_ready  (disp_ready)
    );

    for (genvar e = 0; e < RS_NUM_ENTRIES; e++) begin : g_entry
        rs_entry i_rs_entry (
            .clk              (clk),
            .reset            (reset),
            .nuke             (nuke),
            .alloc            (alloc[e]),
            .alloc_robid      (disp_robid),
            .alloc_pdst       (disp_pdst),
            .alloc_opcode     (disp_opcode),
            .alloc_imm        (disp_imm),
            .alloc_psrc1      (disp_psrc1),
            .alloc_psrc1_pend (disp_psrc1_pend),
            .alloc_psrc2      (disp_psrc2),
            .alloc_psrc2_pend (disp_psrc2_pend),
            .iprf_wr_en       (iprf_wr_en),
            .iprf_wr_preg     (iprf_wr_preg),
            .grant            (grant[e]),
            .valid            (entry_valid[e]),
            .req_issue        (req[e]),
            .robid            (e_robid[e]),
            .pdst             (e_pdst[e]),
            .opcode           (e_opcode[e]),
            .imm              (e_imm[e]),
            .psrc1            (e_psrc1[e]),
            .psrc2            (e_psrc2[e])
        );
    end

    rs_issue_arb i_rs_issue_arb (
        .req        (req),
        .robid      (e_robid),
        .pdst       (e_pdst),
        .opcode     (e_opcode),
        .imm        (e_imm),
        .psrc1      (e_psrc1),
        .psrc2      (e_psrc2),
        .grant      (grant),
        .iss_valid  (iss_valid),
        .iss_robid  (iss_robid),
        .iss_pdst   (iss_pdst),
        .iss_opcode (iss_opcode),
        .iss_imm    (iss_imm),
        .iss_psrc1  (iss_psrc1),
        .iss_psrc2  (iss_psrc2)
    );

endmodule

/* logic/rs_alloc_select.sv */
module rs_alloc_select (
    input  rs_pkg::t_rs_mask entry_valid,
    input  logic             disp_valid,
    input  logic             nuke,

    output rs_pkg::t_rs_mask alloc,
    output logic             disp_ready
);

    import rs_pkg::*;

    t_rs_mask free;
    t_rs_mask lowest_free;
    logic     found;

    assign free = ~entry_valid;

    // Lowest free index wins
    always_comb begin
        lowest_free = '0;
        found       = 1'b0;
        for (int i = 0; i < RS_NUM_ENTRIES; i++) begin
            if (free[i] && !found) begin
                lowest_free[i] = 1'b1;
                found          = 1'b1;
            end
        end
    end

    assign disp_ready = |free;

    // Flush drops a same-cycle dispatch
    assign alloc = lowest_free & {RS_NUM_ENTRIES{disp_valid & ~nuke}};

endmodule

/* logic/rs_entry.sv */
module rs_entry (
    input  logic            clk,
    input  logic            reset,
    input  logic            nuke,

    input  logic            alloc,
    input  rs_pkg::t_robid  alloc_robid,
    input  rs_pkg::t_preg   alloc_pdst,
    input  rs_pkg::t_opcode alloc_opcode,
    input  rs_pkg::t_imm    alloc_imm,
    input  rs_pkg::t_preg   alloc_psrc1,
    input  logic            alloc_psrc1_pend,
    input  rs_pkg::t_preg   alloc_psrc2,
    input  logic            alloc_psrc2_pend,

    input  logic            iprf_wr_en   [rs_pkg::IPRF_NUM_WRITES-1:0],
    input  rs_pkg::t_preg   iprf_wr_preg [rs_pkg::IPRF_NUM_WRITES-1:0],

    input  logic            grant,

    output logic            valid,
    output logic            req_issue,
    output rs_pkg::t_robid  robid,
    output rs_pkg::t_preg   pdst,
    output rs_pkg::t_opcode opcode,
    output rs_pkg::t_imm    imm,
    output rs_pkg::t_preg   psrc1,
    output rs_pkg::t_preg   psrc2
);

    import rs_pkg::*;

    t_rs_ent_fsm state;
    t_rs_ent_fsm state_nxt;

    t_preg                  src_tag  [NUM_SOURCES-1:0];
    logic                   src_pend [NUM_SOURCES-1:0];
    logic [NUM_SOURCES-1:0] src_ready;

    // Entry leaves on issue or flush
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (alloc && !nuke) begin
                    state_nxt = VALID;
                end
            end
            VALID: begin
                if (grant || nuke) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign valid = (state == VALID);

    // Static micro-op fields
    always_ff @(posedge clk) begin
        if (alloc) begin
            robid  <= alloc_robid;
            pdst   <= alloc_pdst;
            opcode <= alloc_opcode;
            imm    <= alloc_imm;
            psrc1  <= alloc_psrc1;
            psrc2  <= alloc_psrc2;
        end
    end

    assign src_tag[0]  = alloc_psrc1;
    assign src_pend[0] = alloc_psrc1_pend;
    assign src_tag[1]  = alloc_psrc2;
    assign src_pend[1] = alloc_psrc2_pend;

    for (genvar s = 0; s < NUM_SOURCES; s++) begin : g_src_trk
        rs_reg_trk i_rs_reg_trk (
            .clk          (clk),
            .reset        (reset),
            .alloc        (alloc),
            .alloc_psrc   (src_tag[s]),
            .alloc_pend   (src_pend[s]),
            .iprf_wr_en   (iprf_wr_en),
            .iprf_wr_preg (iprf_wr_preg),
            .ready        (src_ready[s])
        );
    end

    assign req_issue = valid & (&src_ready);

endmodule

/* logic/rs_issue_arb.sv */
module rs_issue_arb (
    input  rs_pkg::t_rs_mask req,
    input  rs_pkg::t_robid   robid  [rs_pkg::RS_NUM_ENTRIES-1:0],
    input  rs_pkg::t_preg    pdst   [rs_pkg::RS_NUM_ENTRIES-1:0],
    input  rs_pkg::t_opcode  opcode [rs_pkg::RS_NUM_ENTRIES-1:0],
    input  rs_pkg::t_imm     imm    [rs_pkg::RS_NUM_ENTRIES-1:0],
    input  rs_pkg::t_preg    psrc1  [rs_pkg::RS_NUM_ENTRIES-1:0],
    input  rs_pkg::t_preg    psrc2  [rs_pkg::RS_NUM_ENTRIES-1:0],

    output rs_pkg::t_rs_mask grant,
    output logic             iss_valid,
    output rs_pkg::t_robid   iss_robid,
    output rs_pkg::t_preg    iss_pdst,
    output rs_pkg::t_opcode  iss_opcode,
    output rs_pkg::t_imm     iss_imm,
    output rs_pkg::t_preg    iss_psrc1,
    output rs_pkg::t_preg    iss_psrc2
);

    import rs_pkg::*;

    // Isolate the lowest set request bit
    assign grant     = req & (~req + 1'b1);
    assign iss_valid = |req;

    // AND-OR mux under the one-hot grant
    always_comb begin
        iss_robid  = '0;
        iss_pdst   = '0;
        iss_opcode = '0;
        iss_imm    = '0;
        iss_psrc1  = '0;
        iss_psrc2  = '0;
        for (int i = 0; i < RS_NUM_ENTRIES; i++) begin
            iss_robid  |= robid[i]  & {ROBID_W{grant[i]}};
            iss_pdst   |= pdst[i]   & {PREG_W{grant[i]}};
            iss_opcode |= opcode[i] & {OPCODE_W{grant[i]}};
            iss_imm    |= imm[i]    & {IMM_W{grant[i]}};
            iss_psrc1  |= psrc1[i]  & {PREG_W{grant[i]}};
            iss_psrc2  |= psrc2[i]  & {PREG_W{grant[i]}};
        end
    end

endmodule

/* logic/rs_pkg.sv */
package rs_pkg;

    // Station and datapath sizes
    localparam int RS_NUM_ENTRIES  = 4;
    localparam int NUM_SOURCES     = 2;
    localparam int IPRF_NUM_WRITES = 2;

    localparam int PREG_W   = 6;
    localparam int ROBID_W  = 5;
    localparam int OPCODE_W = 8;
    localparam int IMM_W    = 32;

    typedef logic [PREG_W-1:0]   t_preg;
    typedef logic [ROBID_W-1:0]  t_robid;
    typedef logic [OPCODE_W-1:0] t_opcode;
    typedef logic [IMM_W-1:0]    t_imm;

    // One bit per station entry
    typedef logic [RS_NUM_ENTRIES-1:0] t_rs_mask;

    // Entry lifecycle
    typedef enum logic {
        IDLE,
        VALID
    } t_rs_ent_fsm;

endpackage

/* logic/rs_reg_trk.sv */
module rs_reg_trk (
    input  logic          clk,
    input  logic          reset,

    input  logic          alloc,
    input  rs_pkg::t_preg alloc_psrc,
    input  logic          alloc_pend,

    input  logic          iprf_wr_en   [rs_pkg::IPRF_NUM_WRITES-1:0],
    input  rs_pkg::t_preg iprf_wr_preg [rs_pkg::IPRF_NUM_WRITES-1:0],

    output logic          ready
);

    import rs_pkg::*;

    t_preg psrc;
    logic  pend;
    logic  alloc_hit;
    logic  pend_hit;

    // Compare every write port against the incoming tag and the held tag
    always_comb begin
        alloc_hit = 1'b0;
        pend_hit  = 1'b0;
        for (int i = 0; i < IPRF_NUM_WRITES; i++) begin
            if (iprf_wr_en[i] && (iprf_wr_preg[i] == alloc_psrc)) begin
                alloc_hit = 1'b1;
            end
            if (iprf_wr_en[i] && (iprf_wr_preg[i] == psrc)) begin
                pend_hit = 1'b1;
            end
        end
    end

    // A write in the allocation cycle already satisfies the source
    always_ff @(posedge clk) begin
        if (reset) begin
            pend <= 1'b0;
        end else if (alloc) begin
            pend <= alloc_pend & ~alloc_hit;
        end else if (pend_hit) begin
            pend <= 1'b0;
        end
    end

    // Held source tag
    always_ff @(posedge clk) begin
        if (alloc) begin
            psrc <= alloc_psrc;
        end
    end

    assign ready = ~pend;

endmodule

/* reservation_station.f */
logic/rs_pkg.sv
logic/rs_reg_trk.sv
logic/rs_entry.sv
logic/rs_alloc_select.sv
logic/rs_issue_arb.sv
logic/reservation_station.sv
verification/reservation_station_sva.sv
verification/reservation_station_tb.sv

/* verification/reservation_station_sva.sv */
module reservation_station_sva (
    input  logic             clk,
    input  logic             reset,
    input  logic             disp_valid,
    input  logic             disp_ready,
    input  logic             nuke,
    input  logic             iss_valid,
    input  rs_pkg::t_rs_mask req,
    input  rs_pkg::t_rs_mask grant,
    input  rs_pkg::t_rs_mask entry_valid
);

    import rs_pkg::*;

    // Count of failed assertions
    int error_count = 0;

    grant_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(grant))
        else begin
            error_count++;
            $error("grant is not one-hot or zero: %b", grant);
        end

    // Issue valid only while a live entry holds the grant
    iss_valid_any_req: assert property (@(posedge clk) disable iff (reset)
        iss_valid == (|(grant & entry_valid)))
        else begin
            error_count++;
            $error("iss_valid %b does not match granted entries %b of valid %b",
                   iss_valid, grant, entry_valid);
        end

    no_disp_when_full: assert property (@(posedge clk) disable iff (reset)
        disp_valid |-> disp_ready)
        else begin
            error_count++;
            $error("dispatch while disp_ready is low");
        end

    // Flush empties the whole station
    nuke_clears_all: assert property (@(posedge clk) disable iff (reset)
        nuke |=> (entry_valid == t_rs_mask'('0)))
        else begin
            error_count++;
            $error("entries still valid after nuke: %b", entry_valid);
        end

endmodule

/* verification/reservation_station_tb.sv */
module reservation_station_tb;

    import rs_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int RAND_CYCLES = 200;

    // Cycle budget of each test for the watchdog
    localparam int CYC_RESET = 4;
    localparam int CYC_BASIC = 10;
    localparam int CYC_PEND  = 20;
    localparam int CYC_PRIO  = 30;
    localparam int CYC_FULL  = 25;
    localparam int CYC_NUKE  = 15;
    localparam int CYC_RAND  = RAND_CYCLES + 5;
    localparam int TIMEOUT   = (CYC_RESET + CYC_BASIC + CYC_PEND + CYC_PRIO + CYC_FULL
                                + CYC_NUKE + CYC_RAND) * CLK_PERIOD + 50 * CLK_PERIOD;

    logic    clk;
    logic    reset;
    logic    disp_valid;
    t_robid  disp_robid;
    t_preg   disp_pdst;
    t_opcode disp_opcode;
    t_imm    disp_imm;
    t_preg   disp_psrc1;
    logic    disp_psrc1_pend;
    t_preg   disp_psrc2;
    logic    disp_psrc2_pend;
    logic    disp_ready;
    logic    iprf_wr_en   [IPRF_NUM_WRITES-1:0];
    t_preg   iprf_wr_preg [IPRF_NUM_WRITES-1:0];
    logic    nuke;
    logic    iss_valid;
    t_robid  iss_robid;
    t_preg   iss_pdst;
    t_opcode iss_opcode;
    t_imm    iss_imm;
    t_preg   iss_psrc1;
    t_preg   iss_psrc2;

    // Reference model of the entries
    logic    m_valid [RS_NUM_ENTRIES];
    t_robid  m_robid [RS_NUM_ENTRIES];
    t_preg   m_pdst  [RS_NUM_ENTRIES];
    t_opcode m_opcode[RS_NUM_ENTRIES];
    t_imm    m_imm   [RS_NUM_ENTRIES];
    t_preg   m_psrc1 [RS_NUM_ENTRIES];
    t_preg   m_psrc2 [RS_NUM_ENTRIES];
    logic    m_pend1 [RS_NUM_ENTRIES];
    logic    m_pend2 [RS_NUM_ENTRIES];

    integer seed = 32'h26bf;
    int     err_count = 0;
    int     check_count = 0;
    int     test_count = 0;
    int     total_errors;

    reservation_station i_reservation_station (.*);

    bind reservation_station reservation_station_sva i_reservation_station_sva (
        .clk         (clk),
        .reset       (reset),
        .disp_valid  (disp_valid),
        .disp_ready  (disp_ready),
        .nuke        (nuke),
        .iss_valid   (iss_valid),
        .req         (req),
        .grant       (grant),
        .entry_valid (entry_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT);
        $display("timeout: the run did not finish within %0d time units", TIMEOUT);
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic check_val(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("mismatch at time %0t: %s expected %0h actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    function automatic int lowest_ready();
        int idx;
        idx = -1;
        for (int i = RS_NUM_ENTRIES - 1; i >= 0; i--) begin
            if (m_valid[i] && !m_pend1[i] && !m_pend2[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic int lowest_free();
        int idx;
        idx = -1;
        for (int i = RS_NUM_ENTRIES - 1; i >= 0; i--) begin
            if (!m_valid[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic logic write_hits(input t_preg tag);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < IPRF_NUM_WRITES; p++) begin
            if (iprf_wr_en[p] && (iprf_wr_preg[p] == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // Advance the model by the edge that sampled the current inputs
    task automatic update_model();
        int g;
        int f;
        g = lowest_ready();
        f = lowest_free();
        for (int i = 0; i < RS_NUM_ENTRIES; i++) begin
            if (m_valid[i]) begin
                if (nuke || (i == g)) begin
                    m_valid[i] = 1'b0;
                end else begin
                    if (write_hits(m_psrc1[i])) m_pend1[i] = 1'b0;
                    if (write_hits(m_psrc2[i])) m_pend2[i] = 1'b0;
                end
            end
        end
        if (disp_valid && !nuke && (f >= 0)) begin
            m_valid[f]  = 1'b1;
            m_robid[f]  = disp_robid;
            m_pdst[f]   = disp_pdst;
            m_opcode[f] = disp_opcode;
            m_imm[f]    = disp_imm;
            m_psrc1[f]  = disp_psrc1;
            m_psrc2[f]  = disp_psrc2;
            m_pend1[f]  = disp_psrc1_pend && !write_hits(disp_psrc1);
            m_pend2[f]  = disp_psrc2_pend && !write_hits(disp_psrc2);
        end
    endtask

    task automatic check_outputs();
        int g;
        g = lowest_ready();
        check_val("disp_ready", lowest_free() >= 0, disp_ready);
        check_val("iss_valid", g >= 0, iss_valid);
        if (g >= 0) begin
            check_val("iss_robid", m_robid[g], iss_robid);
            check_val("iss_pdst", m_pdst[g], iss_pdst);
            check_val("iss_opcode", m_opcode[g], iss_opcode);
            check_val("iss_imm", m_imm[g], iss_imm);
            check_val("iss_psrc1", m_psrc1[g], iss_psrc1);
            check_val("iss_psrc2", m_psrc2[g], iss_psrc2);
        end
    endtask

    // Model step, input idling and output check for one clock
    task automatic run_cycle();
        @(negedge clk);
        update_model();
        disp_valid = 1'b0;
        nuke       = 1'b0;
        for (int p = 0; p < IPRF_NUM_WRITES; p++) begin
            iprf_wr_en[p] = 1'b0;
        end
        check_outputs();
    endtask

    task automatic drain(input int max_cycles);
        int n;
        n = 0;
        while ((lowest_free() != 0 || m_valid[0] || lowest_ready() >= 0)
               && n < max_cycles && (m_valid[0] || m_valid[1] || m_valid[2] || m_valid[3])) begin
            run_cycle();
            n++;
        end
    endtask

    task automatic drive_dispatch(input t_robid robid, input t_preg pdst, input t_opcode opcode,
                                  input t_imm imm, input t_preg psrc1, input logic pend1,
                                  input t_preg psrc2, input logic pend2);
        disp_valid      = 1'b1;
        disp_robid      = robid;
        disp_pdst       = pdst;
        disp_opcode     = opcode;
        disp_imm        = imm;
        disp_psrc1      = psrc1;
        disp_psrc1_pend = pend1;
        disp_psrc2      = psrc2;
        disp_psrc2_pend = pend2;
    endtask

    task automatic drive_wakeup(input int port, input t_preg tag);
        iprf_wr_en[port]   = 1'b1;
        iprf_wr_preg[port] = tag;
    endtask

    task automatic finish_test(input string name);
        test_count++;
        $display("test %s finished, errors so far %0d", name, err_count);
    endtask

    task automatic test_basic_issue();
        run_cycle();
        drive_dispatch(5'd3, 6'd10, 8'h21, t_imm'($random(seed)), 6'd4, 1'b0, 6'd7, 1'b0);
        run_cycle();
        run_cycle();
        drain(4);
        finish_test("basic_issue");
    endtask

    task automatic test_pending_sources();
        drive_dispatch(5'd1, 6'd11, 8'h40, t_imm'($random(seed)), 6'd5, 1'b1, 6'd9, 1'b1);
        repeat (3) run_cycle();
        drive_wakeup(0, 6'd5);
        run_cycle();
        run_cycle();
        // Second source woken on the other write port
        drive_wakeup(1, 6'd9);
        run_cycle();
        run_cycle();
        // Wakeup in the dispatch cycle counts as ready
        drive_dispatch(5'd2, 6'd12, 8'h41, t_imm'($random(seed)), 6'd12, 1'b1, 6'd13, 1'b1);
        drive_wakeup(0, 6'd12);
        drive_wakeup(1, 6'd13);
        run_cycle();
        drain(4);
        finish_test("pending_sources");
    endtask

    task automatic test_priority();
        for (int i = 0; i < RS_NUM_ENTRIES; i++) begin
            drive_dispatch(t_robid'(4 + i), t_preg'(16 + i), t_opcode'(8'h50 + i),
                           t_imm'($random(seed)), 6'd1, 1'b0, 6'd2, 1'b0);
            run_cycle();
        end
        drain(6);
        // Fill all four behind one shared tag and release them together
        for (int i = 0; i < RS_NUM_ENTRIES; i++) begin
            drive_dispatch(t_robid'(8 + i), t_preg'(20 + i), t_opcode'(8'h60 + i),
                           t_imm'($random(seed)), 6'd30, 1'b1, t_preg'(31 + i), 1'b0);
            run_cycle();
        end
        drive_wakeup(0, 6'd30);
        run_cycle();
        run_cycle();
        // Refill lands in entry 0 and overtakes entries 2 and 3
        drive_dispatch(5'd12, 6'd24, 8'h6f, t_imm'($random(seed)), 6'd3, 1'b0, 6'd4, 1'b0);
        run_cycle();
        drain(8);
        finish_test("priority");
    endtask

    task automatic test_full_station();
        for (int i = 0; i < RS_NUM_ENTRIES; i++) begin
            drive_dispatch(t_robid'(16 + i), t_preg'(32 + i), t_opcode'(8'h70 + i),
                           t_imm'($random(seed)), t_preg'(40 + i), 1'b1, 6'd6, 1'b0);
            run_cycle();
        end
        check_val("disp_ready", 1'b0, disp_ready);
        run_cycle();
        drive_wakeup(1, 6'd42);
        run_cycle();
        run_cycle();
        check_val("disp_ready", 1'b1, disp_ready);
        drive_dispatch(5'd20, 6'd36, 8'h74, t_imm'($random(seed)), 6'd7, 1'b0, 6'd8, 1'b0);
        run_cycle();
        drive_wakeup(0, 6'd40);
        drive_wakeup(1, 6'd41);
        run_cycle();
        drive_wakeup(0, 6'd43);
        run_cycle();
        drain(8);
        finish_test("full_station");
    endtask

    task automatic test_nuke();
        drive_dispatch(5'd24, 6'd44, 8'h80, t_imm'($random(seed)), 6'd50, 1'b1, 6'd1, 1'b0);
        run_cycle();
        drive_dispatch(5'd25, 6'd45, 8'h81, t_imm'($random(seed)), 6'd2, 1'b0, 6'd51, 1'b1);
        run_cycle();
        drive_dispatch(5'd26, 6'd46, 8'h82, t_imm'($random(seed)), 6'd3, 1'b0, 6'd4, 1'b0);
        run_cycle();
        // Flush with a dropped dispatch in the same cycle
        nuke = 1'b1;
        drive_dispatch(5'd27, 6'd47, 8'h83, t_imm'($random(seed)), 6'd5, 1'b0, 6'd6, 1'b0);
        run_cycle();
        drive_wakeup(0, 6'd50);
        drive_wakeup(1, 6'd51);
        repeat (3) run_cycle();
        finish_test("nuke");
    endtask

    task automatic test_random_mix();
        for (int n = 0; n < RAND_CYCLES; n++) begin
            if ((lowest_free() >= 0) && ($random(seed) & 1)) begin
                drive_dispatch(t_robid'($random(seed)), t_preg'($random(seed)),
                               t_opcode'($random(seed)), t_imm'($random(seed)),
                               t_preg'($random(seed) & 15), 1'($random(seed)),
                               t_preg'($random(seed) & 15), 1'($random(seed)));
            end
            for (int p = 0; p < IPRF_NUM_WRITES; p++) begin
                if (($random(seed) & 3) == 0) begin
                    drive_wakeup(p, t_preg'($random(seed) & 15));
                end
            end
            if (($random(seed) & 31) == 0) begin
                nuke = 1'b1;
            end
            run_cycle();
        end
        finish_test("random_mix");
    endtask

    initial begin
        reset           = 1'b1;
        nuke            = 1'b0;
        disp_valid      = 1'b0;
        disp_robid      = '0;
        disp_pdst       = '0;
        disp_opcode     = '0;
        disp_imm        = '0;
        disp_psrc1      = '0;
        disp_psrc1_pend = 1'b0;
        disp_psrc2      = '0;
        disp_psrc2_pend = 1'b0;
        for (int p = 0; p < IPRF_NUM_WRITES; p++) begin
            iprf_wr_en[p]   = 1'b0;
            iprf_wr_preg[p] = '0;
        end
        for (int i = 0; i < RS_NUM_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
            m_pend1[i] = 1'b0;
            m_pend2[i] = 1'b0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_basic_issue();
        test_pending_sources();
        test_priority();
        test_full_station();
        test_nuke();
        test_random_mix();
        run_cycle();

        total_errors = err_count + i_reservation_station.i_reservation_station_sva.error_count;
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, total_errors);
        if (total_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
